/* compile.f */
prefetch_pkg.sv
fetch_fifo_if.sv
prefetch_controller.sv
fetch_fifo.sv
obi_instr_port.sv
prefetch_buffer.sv
tb_instr_mem.sv
tb_prefetch_buffer.sv

/* fetch_fifo.sv */
////////////////////////////////////////////////////////////
// Response FIFO of the prefetch buffer
// Circular buffer of DEPTH words with flush
// An empty FIFO passes the bus response straight through
////////////////////////////////////////////////////////////

module fetch_fifo #(
  parameter int DEPTH = 2
) (
  input  logic                clk,
  input  logic                rst_i,

  // Word returned by the bus port
  input  prefetch_pkg::word_t resp_rdata_i,
  // Word presented to the core
  output prefetch_pkg::word_t fetch_rdata_o,

  // Control and status
  fetch_fifo_if.fifo          fifo
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  // Storage
  prefetch_pkg::word_t mem [DEPTH];

  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  logic             do_push;
  logic             do_pop;

  // Flush wins over push and pop in the same cycle
  assign do_push = fifo.push && !fifo.flush;
  assign do_pop  = fifo.pop && !fifo.flush && (cnt_q != '0);

  assign fifo.cnt   = cnt_q;
  assign fifo.empty = (cnt_q == '0);

  // Head word, or the live response when nothing is buffered
  assign fetch_rdata_o = fifo.empty ? resp_rdata_i : mem[rd_ptr_q];

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////

  // Pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk) begin
    if (rst_i || fifo.flush) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + CNT_W'(1);
        2'b01:   cnt_q <= cnt_q - CNT_W'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Word storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= resp_rdata_i;
    end
  end

endmodule

/* fetch_fifo_if.sv */
////////////////////////////////////////////////////////////
// Control and status bundle between the prefetch controller
// and the response FIFO
// The controller drives push, pop and flush
////////////////////////////////////////////////////////////

interface fetch_fifo_if #(
  parameter int DEPTH = 2
);

  // Count runs from 0 up to DEPTH inclusive
  localparam int CNT_W = $clog2(DEPTH) + 1;

  // Write the current response word
  logic             push;
  // Drop the head word
  logic             pop;
  // Empty the FIFO for the next cycle
  logic             flush;
  // Number of buffered words
  logic [CNT_W-1:0] cnt;
  // No word buffered
  logic             empty;

  // Controller side
  modport controller (
    output push,
    output pop,
    output flush,
    input  cnt,
    input  empty
  );

  // FIFO side
  modport fifo (
    input  push,
    input  pop,
    input  flush,
    output cnt,
    output empty
  );

endinterface

/* obi_instr_port.sv */
////////////////////////////////////////////////////////////
// Instruction bus port on OBI req/gnt and rvalid
// Transparent until a request waits for its grant, then
// holds address and req stable until the grant
////////////////////////////////////////////////////////////

module obi_instr_port (
  input  logic                clk,
  input  logic                rst_i,

  // Transaction request from the controller
  input  logic                trans_valid_i,
  output logic                trans_ready_o,
  input  prefetch_pkg::word_t trans_addr_i,

  // Transaction response
  output logic                resp_valid_o,
  output prefetch_pkg::word_t resp_rdata_o,

  // Instruction bus
  output logic                instr_req_o,
  input  logic                instr_gnt_i,
  output prefetch_pkg::word_t instr_addr_o,
  input  prefetch_pkg::word_t instr_rdata_i,
  input  logic                instr_rvalid_i
);

  prefetch_pkg::obi_state_e state_q, state_d;

  // Address of the request that waits for grant
  prefetch_pkg::word_t addr_q;

  ////////////////////////////////////////////////////////////
  // Request phase
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    trans_ready_o = instr_gnt_i;
    case (state_q)
      prefetch_pkg::OBI_PASS: begin
        instr_req_o  = trans_valid_i;
        instr_addr_o = trans_addr_i;
        // Request without grant is frozen from the next cycle
        if (trans_valid_i && !instr_gnt_i) begin
          state_d = prefetch_pkg::OBI_HELD;
        end
      end
      prefetch_pkg::OBI_HELD: begin
        // Controller address changes are ignored here
        instr_req_o  = 1'b1;
        instr_addr_o = addr_q;
        if (instr_gnt_i) begin
          state_d = prefetch_pkg::OBI_PASS;
        end
      end
      default: begin
        instr_req_o  = 1'b0;
        instr_addr_o = trans_addr_i;
        state_d      = prefetch_pkg::OBI_PASS;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= prefetch_pkg::OBI_PASS;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the address when entering the held state
  always_ff @(posedge clk) begin
    if ((state_q == prefetch_pkg::OBI_PASS) && trans_valid_i && !instr_gnt_i) begin
      addr_q <= trans_addr_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response phase
  ////////////////////////////////////////////////////////////

  // In order responses need no tagging
  assign resp_valid_o = instr_rvalid_i;
  assign resp_rdata_o = instr_rdata_i;

endmodule

/* prefetch_buffer.sv */
////////////////////////////////////////////////////////////
// Instruction prefetch buffer top level
// Sits between the core fetch stage and the instruction bus
// Joins the controller, the response FIFO and the bus port
////////////////////////////////////////////////////////////

module prefetch_buffer #(
  // FIFO depth and limit of outstanding requests
  // Power of two and at least 2
  parameter int DEPTH = 2
) (
  input  logic                clk,
  input  logic                rst_i,

  // Core fetch side
  input  logic                req_i,
  input  logic                branch_i,
  input  prefetch_pkg::word_t branch_addr_i,
  input  logic                fetch_ready_i,
  output logic                fetch_valid_o,
  output prefetch_pkg::word_t fetch_rdata_o,

  // Instruction bus
  output logic                instr_req_o,
  input  logic                instr_gnt_i,
  output prefetch_pkg::word_t instr_addr_o,
  input  prefetch_pkg::word_t instr_rdata_i,
  input  logic                instr_rvalid_i,

  // High while requests are outstanding or words are buffered
  output logic                busy_o
);

  // Transaction request between controller and bus port
  logic                trans_valid;
  logic                trans_ready;
  prefetch_pkg::word_t trans_addr;

  // Transaction response from the bus port
  logic                resp_valid;
  prefetch_pkg::word_t resp_rdata;

  // FIFO control and status
  fetch_fifo_if #(.DEPTH(DEPTH)) fifo_bus ();

  ////////////////////////////////////////////////////////////
  // Controller
  ////////////////////////////////////////////////////////////

  prefetch_controller #(
    .DEPTH (DEPTH)
  ) i_prefetch_controller (
    .clk           (clk),
    .rst_i         (rst_i),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .busy_o        (busy_o),
    .trans_valid_o (trans_valid),
    .trans_ready_i (trans_ready),
    .trans_addr_o  (trans_addr),
    .resp_valid_i  (resp_valid),
    .fetch_ready_i (fetch_ready_i),
    .fetch_valid_o (fetch_valid_o),
    .fifo          (fifo_bus.controller)
  );

  ////////////////////////////////////////////////////////////
  // Response FIFO with fall-through
  ////////////////////////////////////////////////////////////

  fetch_fifo #(
    .DEPTH (DEPTH)
  ) i_fetch_fifo (
    .clk           (clk),
    .rst_i         (rst_i),
    .resp_rdata_i  (resp_rdata),
    .fetch_rdata_o (fetch_rdata_o),
    .fifo          (fifo_bus.fifo)
  );

  ////////////////////////////////////////////////////////////
  // Bus port
  ////////////////////////////////////////////////////////////

  obi_instr_port i_obi_instr_port (
    .clk            (clk),
    .rst_i          (rst_i),
    .trans_valid_i  (trans_valid),
    .trans_ready_o  (trans_ready),
    .trans_addr_i   (trans_addr),
    .resp_valid_o   (resp_valid),
    .resp_rdata_o   (resp_rdata),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i)
  );

endmodule

/* prefetch_controller.sv */
////////////////////////////////////////////////////////////
// Prefetch control logic
// Tracks the next fetch address and the outstanding bus
// requests, drops stale responses after a branch and
// drives the response FIFO
////////////////////////////////////////////////////////////

module prefetch_controller #(
  parameter int DEPTH = 2
) (
  input  logic                   clk,
  input  logic                   rst_i,

  // Core side
  input  logic                   req_i,
  input  logic                   branch_i,
  input  prefetch_pkg::word_t    branch_addr_i,
  output logic                   busy_o,

  // Transaction request towards the bus port
  output logic                   trans_valid_o,
  input  logic                   trans_ready_i,
  output prefetch_pkg::word_t    trans_addr_o,

  // Transaction response from the bus port
  input  logic                   resp_valid_i,

  // Fetch handshake towards the core
  input  logic                   fetch_ready_i,
  output logic                   fetch_valid_o,

  // FIFO control
  fetch_fifo_if.controller       fifo
);

  localparam int CNT_W = $clog2(DEPTH) + 1;

  prefetch_pkg::pf_state_e state_q, state_d;

  // Next word-aligned fetch address
  prefetch_pkg::word_t addr_q, addr_d;

  // Granted requests still waiting for rvalid
  logic [CNT_W-1:0] out_q, out_d;
  // How many of those belong to an old stream
  logic [CNT_W-1:0] stale_q, stale_d;

  // Request raised but not yet accepted
  logic held_q, held_d;
  // The held request was issued before a branch
  logic held_stale_q, held_stale_d;

  logic             accept;
  logic             advance;
  logic             resp_stale;
  logic             resp_live;
  logic [CNT_W:0]   inflight;
  logic             room;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  // Outstanding requests plus buffered words bound the FIFO use
  assign inflight = {1'b0, out_q} + {1'b0, fifo.cnt};
  assign room     = (inflight < (CNT_W + 1)'(DEPTH));

  // A raised request stays up until the bus port accepts it
  // New requests wait for the branch cycle to pass
  assign trans_valid_o = held_q ||
                         ((state_q == prefetch_pkg::PF_FETCH) && req_i && !branch_i && room);
  assign trans_addr_o  = addr_q;

  assign accept  = trans_valid_o && trans_ready_i;
  // Only requests of the current stream move the address
  assign advance = accept && !held_stale_q && !branch_i;

  assign held_d       = trans_valid_o && !trans_ready_i;
  assign held_stale_d = held_d && (branch_i || held_stale_q);

  ////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////

  // Responses are in order so the oldest ones are the stale ones
  assign resp_stale = resp_valid_i && (stale_q != '0);
  // Anything arriving in the branch cycle is older than the branch
  assign resp_live  = resp_valid_i && (stale_q == '0) && !branch_i;

  // Fall through when the FIFO is empty and the core takes the word
  assign fifo.push  = resp_live && !(fifo.empty && fetch_ready_i);
  assign fifo.pop   = fifo.empty ? 1'b0 : (fetch_ready_i && !branch_i);
  assign fifo.flush = branch_i;

  // The core ignores the branch cycle
  assign fetch_valid_o = !branch_i && (!fifo.empty || resp_live);

  assign busy_o = (out_q != '0) || !fifo.empty;

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      prefetch_pkg::PF_IDLE: begin
        // Fetching starts with the first branch
        if (branch_i) begin
          state_d = prefetch_pkg::PF_FETCH;
        end
      end
      prefetch_pkg::PF_FETCH: begin
        // Later branches only redirect the address
        state_d = prefetch_pkg::PF_FETCH;
      end
      default: begin
        state_d = prefetch_pkg::PF_IDLE;
      end
    endcase
  end

  // Fetch address
  always_comb begin
    addr_d = addr_q;
    if (branch_i) begin
      addr_d = {branch_addr_i[prefetch_pkg::ADDR_W-1:2], 2'b00};
    end else if (advance) begin
      addr_d = addr_q + prefetch_pkg::word_t'(4);
    end
  end

  // Outstanding and stale counters
  always_comb begin
    out_d = out_q;
    if (accept) begin
      out_d = out_d + CNT_W'(1);
    end
    if (resp_valid_i) begin
      out_d = out_d - CNT_W'(1);
    end

    stale_d = stale_q;
    if (branch_i) begin
      // Everything still in flight after this cycle is stale
      stale_d = out_d;
    end else begin
      if (resp_stale) begin
        stale_d = stale_d - CNT_W'(1);
      end
      // A held request from before the branch joins the stale ones
      if (accept && held_stale_q) begin
        stale_d = stale_d + CNT_W'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q      <= prefetch_pkg::PF_IDLE;
      addr_q       <= '0;
      out_q        <= '0;
      stale_q      <= '0;
      held_q       <= 1'b0;
      held_stale_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      addr_q       <= addr_d;
      out_q        <= out_d;
      stale_q      <= stale_d;
      held_q       <= held_d;
      held_stale_q <= held_stale_d;
    end
  end

endmodule

/* prefetch_pkg.sv */
////////////////////////////////////////////////////////////
// Shared types for the instruction prefetch buffer
// Holds the word type, the address width and the FSM state
// encodings used by the controller and the bus port
////////////////////////////////////////////////////////////

package prefetch_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and data types
  ////////////////////////////////////////////////////////////

  // Instruction address width in bits
  localparam int ADDR_W = 32;

  // One instruction word or one fetch address
  typedef logic [ADDR_W-1:0] word_t;

  ////////////////////////////////////////////////////////////
  // State encodings
  ////////////////////////////////////////////////////////////

  // Prefetch controller FSM
  // PF_IDLE waits for the first branch after reset
  // PF_FETCH issues requests whenever there is room
  typedef enum logic {
    PF_IDLE,
    PF_FETCH
  } pf_state_e;

  // Bus port FSM
  // OBI_PASS forwards the controller request combinationally
  // OBI_HELD drives the registered address until the grant
  typedef enum logic {
    OBI_PASS,
    OBI_HELD
  } obi_state_e;

endpackage

/* tb_instr_mem.sv */
////////////////////////////////////////////////////////////
// Behavioral instruction memory for the prefetch testbench
// Grants after 0 to 3 cycles and answers in order after 1 to
// 4 cycles, and counts granted but unanswered requests
////////////////////////////////////////////////////////////

module tb_instr_mem #(
  parameter logic [31:0] SEED = 32'h6ffe_3231
) (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                instr_req_i,
  input  prefetch_pkg::word_t instr_addr_i,
  output logic                instr_gnt_o,
  output prefetch_pkg::word_t instr_rdata_o,
  output logic                instr_rvalid_o,
  output int                  outstanding_o
);

  logic [31:0] rng_state;
  // Cycles left before the next grant
  int          gnt_wait_q;
  int          cycle_q;

  // Granted addresses in order, with the cycle each one may answer
  prefetch_pkg::word_t pend_addr [$];
  int                  pend_due [$];

  initial begin
    rng_state = SEED;
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'((lcg_next() >> 8) % n);
  endfunction

  // Upper half inverted, lower half as is
  function automatic prefetch_pkg::word_t mem_word(input prefetch_pkg::word_t a);
    return {~a[31:16], a[15:0]};
  endfunction

  assign instr_gnt_o = instr_req_i && (gnt_wait_q == 0);

  always @(posedge clk) begin
    if (rst_i) begin
      gnt_wait_q     <= rand_below(4);
      cycle_q        <= 0;
      instr_rvalid_o <= 1'b0;
      instr_rdata_o  <= '0;
      outstanding_o  <= 0;
      pend_addr.delete();
      pend_due.delete();
    end else begin
      cycle_q <= cycle_q + 1;
      // Accept the request and pick the next grant delay
      if (instr_gnt_o) begin
        pend_addr.push_back(instr_addr_i);
        pend_due.push_back(cycle_q + rand_below(4));
        gnt_wait_q <= rand_below(4);
      end else if (instr_req_i && (gnt_wait_q > 0)) begin
        gnt_wait_q <= gnt_wait_q - 1;
      end
      // At most one response per cycle, oldest first
      instr_rvalid_o <= 1'b0;
      if ((pend_addr.size() > 0) && (pend_due[0] <= cycle_q)) begin
        instr_rvalid_o <= 1'b1;
        instr_rdata_o  <= mem_word(pend_addr[0]);
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      // The rvalid cycle still counts, like the DUT's own counter
      outstanding_o <= outstanding_o + (instr_gnt_o ? 1 : 0) - (instr_rvalid_o ? 1 : 0);
    end
  end

endmodule

/* tb_prefetch_buffer.sv */
////////////////////////////////////////////////////////////
// Testbench for the instruction prefetch buffer
// Random core stimulus against a fetch-order model, with
// bus-side monitors for the outstanding limit and stability
////////////////////////////////////////////////////////////

module tb_prefetch_buffer;

  localparam int          DEPTH     = 2;
  localparam logic [31:0] SEED      = 32'h6ffe_3231;
  // Cycles allowed per expected transfer
  localparam int          XFER_WAIT = 40;

  logic                clk;
  logic                rst_i;
  logic                req_i;
  logic                branch_i;
  prefetch_pkg::word_t branch_addr_i;
  logic                fetch_ready_i;
  logic                fetch_valid_o;
  prefetch_pkg::word_t fetch_rdata_o;
  logic                instr_req_o;
  logic                instr_gnt_i;
  prefetch_pkg::word_t instr_addr_o;
  prefetch_pkg::word_t instr_rdata_i;
  logic                instr_rvalid_i;
  logic                busy_o;
  int                  mem_outstanding;

  logic [31:0]         rng_state;
  string               cur_test;
  // Fetch-order model
  prefetch_pkg::word_t exp_addr;
  prefetch_pkg::word_t exp_word;
  int                  xfer_cnt;
  // Bus request seen waiting for grant in the previous cycle
  logic                wait_prev;
  prefetch_pkg::word_t addr_prev;
  int                  phase_err;
  int                  limit_err;
  int                  stable_err;
  int                  test_cnt;
  int                  fail_cnt;

  prefetch_buffer #(
    .DEPTH (DEPTH)
  ) i_prefetch_buffer (
    .clk            (clk),
    .rst_i          (rst_i),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .fetch_ready_i  (fetch_ready_i),
    .fetch_valid_o  (fetch_valid_o),
    .fetch_rdata_o  (fetch_rdata_o),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i),
    .busy_o         (busy_o)
  );

  tb_instr_mem #(
    .SEED (~SEED)
  ) i_instr_mem (
    .clk            (clk),
    .rst_i          (rst_i),
    .instr_req_i    (instr_req_o),
    .instr_addr_i   (instr_addr_o),
    .instr_gnt_o    (instr_gnt_i),
    .instr_rdata_o  (instr_rdata_i),
    .instr_rvalid_o (instr_rvalid_i),
    .outstanding_o  (mem_outstanding)
  );

  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'((lcg_next() >> 8) % n);
  endfunction

  // Memory content with the upper half of the address inverted
  function automatic prefetch_pkg::word_t expected_word(input prefetch_pkg::word_t a);
    return {~a[31:16], a[15:0]};
  endfunction

  // Inputs change 2 time units after the rising edge
  task automatic drive_cycle(input logic req, input logic ready, input logic branch,
                             input prefetch_pkg::word_t target);
    @(posedge clk);
    #2;
    req_i         = req;
    fetch_ready_i = ready;
    branch_i      = branch;
    branch_addr_i = target;
  endtask

  task automatic abort_run(input string why);
    $display("TIMEOUT in %s: %s", cur_test, why);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  // Keeps fetching until n more transfers happen or time runs out
  task automatic run_transfers(input int n, input int ready_pct);
    int target;
    int cycles;
    target = xfer_cnt + n;
    cycles = 0;
    while ((xfer_cnt < target) && (cycles < n * XFER_WAIT)) begin
      drive_cycle(1'b1, rand_below(100) < ready_pct, 1'b0, '0);
      cycles++;
    end
    if (xfer_cnt < target) begin
      abort_run($sformatf("only %0d of %0d transfers arrived", n - (target - xfer_cnt), n));
    end
  endtask

  task automatic report_test(input string name, input int errors);
    test_cnt++;
    if (errors == 0) begin
      $display("PASS %s", name);
    end else begin
      fail_cnt++;
      $display("FAIL %s with %0d errors", name, errors);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor and model sampled at the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_i) begin
      wait_prev = 1'b0;
    end else begin
      // A branch restarts the stream at the target rounded down to a word
      if (branch_i) begin
        exp_addr = branch_addr_i & ~32'd3;
      end else if (fetch_valid_o && fetch_ready_i) begin
        exp_word = expected_word(exp_addr);
        assert (fetch_rdata_o == exp_word) else begin
          $display("ERROR %s: word at %h expected %h actual %h",
                   cur_test, exp_addr, exp_word, fetch_rdata_o);
          phase_err++;
        end
        exp_addr = exp_addr + 32'd4;
        xfer_cnt++;
      end
      assert (mem_outstanding <= DEPTH) else begin
        $display("ERROR outstanding_limit: expected at most %0d actual %0d",
                 DEPTH, mem_outstanding);
        limit_err++;
      end
      if (instr_req_o) begin
        assert (instr_addr_o[1:0] == 2'b00) else begin
          $display("ERROR request_stability: low address bits expected 0 actual %0d",
                   instr_addr_o[1:0]);
          stable_err++;
        end
      end
      // Request and address must hold until granted
      if (wait_prev) begin
        assert (instr_req_o) else begin
          $display("Bus request was dropped before it was granted");
          stable_err++;
        end
        assert (instr_addr_o == addr_prev) else begin
          $display("ERROR request_stability: address expected %h actual %h",
                   addr_prev, instr_addr_o);
          stable_err++;
        end
      end
      wait_prev = instr_req_o && !instr_gnt_i;
      addr_prev = instr_addr_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int                  start_err;
    int                  cycles;
    prefetch_pkg::word_t target;
    rng_state     = SEED;
    rst_i         = 1'b1;
    req_i         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    fetch_ready_i = 1'b0;
    exp_addr      = '0;
    exp_word      = '0;
    xfer_cnt      = 0;
    wait_prev     = 1'b0;
    addr_prev     = '0;
    phase_err     = 0;
    limit_err     = 0;
    stable_err    = 0;
    test_cnt      = 0;
    fail_cnt      = 0;
    cur_test      = "reset";

    repeat (8) @(posedge clk);
    #2;
    rst_i = 1'b0;
    #1;
    start_err = phase_err;
    assert (!instr_req_o && !fetch_valid_o && !busy_o) else begin
      $display("ERROR reset: req/valid/busy expected 000 actual %b%b%b",
               instr_req_o, fetch_valid_o, busy_o);
      phase_err++;
    end
    report_test("reset", phase_err - start_err);

    // Sequential stream from an aligned start
    cur_test  = "sequential";
    start_err = phase_err;
    target    = lcg_next();
    target    = {target[31:2], 2'b00};
    drive_cycle(1'b1, 1'b1, 1'b1, target);
    run_transfers(64, 100);
    report_test("sequential", phase_err - start_err);

    // Redirects back to back or with requests in flight
    cur_test  = "branch_redirect";
    start_err = phase_err;
    for (int i = 0; i < 24; i++) begin
      if (rand_below(2) == 1) begin
        repeat (rand_below(3)) drive_cycle(1'b1, rand_below(2) == 1, 1'b0, '0);
        drive_cycle(1'b1, 1'b1, 1'b1, lcg_next());
      end
      repeat (rand_below(4)) drive_cycle(1'b1, rand_below(2) == 1, 1'b0, '0);
      drive_cycle(1'b1, 1'b1, 1'b1, lcg_next());
      run_transfers(1 + rand_below(3), 80);
    end
    report_test("branch_redirect", phase_err - start_err);

    // Random core stalls
    cur_test  = "back_pressure";
    start_err = phase_err;
    run_transfers(200, 50);
    report_test("back_pressure", phase_err - start_err);

    // Stop fetching and drain what is left
    cur_test  = "idle_busy";
    start_err = phase_err;
    cycles    = 0;
    drive_cycle(1'b0, 1'b1, 1'b0, '0);
    while ((busy_o || instr_req_o) && (cycles < 100)) begin
      drive_cycle(1'b0, 1'b1, 1'b0, '0);
      cycles++;
    end
    if (busy_o || instr_req_o) begin
      abort_run("busy_o did not fall after req_i was dropped");
    end
    repeat (4) drive_cycle(1'b0, 1'b1, 1'b0, '0);
    #1;
    assert (!instr_req_o && !fetch_valid_o && !busy_o) else begin
      $display("ERROR idle_busy: req/valid/busy expected 000 actual %b%b%b",
               instr_req_o, fetch_valid_o, busy_o);
      phase_err++;
    end
    report_test("idle_busy", phase_err - start_err);

    // Bus monitors ran through all the tests above
    report_test("outstanding_limit", limit_err);
    report_test("request_stability", stable_err);

    $display("Tests run: %0d, failed: %0d, transfers: %0d", test_cnt, fail_cnt, xfer_cnt);
    if (fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
